//--- Bender.yml
package:
  name: simon

sources:
  - game_pkg.sv
  - panel_pkg.sv
  - step_timer.sv
  - sequence_gen.sv
  - input_checker.sv
  - game_fsm.sv
  - simon_top.sv
  - target: test
    files:
      - tb_simon.sv

//--- flist.f
game_pkg.sv
panel_pkg.sv
step_timer.sv
sequence_gen.sv
input_checker.sv
game_fsm.sv
simon_top.sv
tb_simon.sv

//--- game_fsm.sv
`timescale 1ns/1ps

module game_fsm
    import game_pkg::*;
    import panel_pkg::*;
#(
    parameter int  MAX_STEPS = 5,
    parameter int  MAX_ROUND = 7,
    localparam int LEN_W     = $clog2(MAX_STEPS + 1)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               tick,
    input  logic               gen_busy,
    input  logic [LEN_W-1:0]   seq_len,
    input  step_t              rd_step,
    input  logic               step_ok,
    input  logic               step_bad,
    output logic               gen_start,
    output logic               tick_enable,
    output logic [LEN_W-1:0]   rd_index,
    output logic               check_arm,
    output logic               capture,
    output logic               in_show,
    output logic [ROUND_W-1:0] round,
    output panel_out_t         display
);

    game_state_t        state;
    logic               gen_sent;               // Sequence job issued this round
    logic               lit;                    // Playback step currently shown
    logic               flash;
    logic               game_over;
    logic [ROUND_W-1:0] highest;
    logic [ROUND_W-1:0] round_next;
    logic               last_step;

    assign last_step  = (rd_index == seq_len - 1'b1);
    assign round_next = (round < ROUND_W'(MAX_ROUND)) ? round + 1'b1 : round;

    assign gen_start   = (state == state_init) && !gen_sent && !gen_busy;
    assign capture     = (state == state_init) && gen_sent && !gen_busy; // Sequence ready
    assign tick_enable = (state == state_show) || (state == state_over);
    assign check_arm   = (state == state_show) || (state == state_input);
    assign in_show     = (state == state_show);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= state_init;
            gen_sent  <= 1'b0;
            lit       <= 1'b0;
            flash     <= 1'b0;
            game_over <= 1'b0;
            rd_index  <= '0;
            round     <= ROUND_W'(1);
            highest   <= ROUND_W'(1);
        end else begin
            case (state)
                state_init: begin
                    if (gen_start) gen_sent <= 1'b1;
                    if (capture) begin
                        state    <= state_show;
                        rd_index <= '0;
                        lit      <= 1'b0;
                    end
                end
                state_show: begin
                    if (step_bad) begin
                        state     <= state_over;
                        game_over <= 1'b1;
                        flash     <= 1'b1;
                    end else if (tick) begin
                        // Show on one tick, blank on the next
                        lit <= !lit;
                        if (lit && last_step) begin
                            state    <= state_input;
                            rd_index <= '0;
                        end else if (lit) begin
                            rd_index <= rd_index + 1'b1;
                        end
                    end
                end
                state_input: begin
                    if (step_bad) begin
                        state     <= state_over;
                        game_over <= 1'b1;
                        flash     <= 1'b1;
                    end else if (step_ok && last_step) begin
                        state    <= state_init;
                        gen_sent <= 1'b0;
                        rd_index <= '0;
                        round    <= round_next; // Saturates at the last round
                        if (round_next > highest) highest <= round_next;
                    end else if (step_ok) begin
                        rd_index <= rd_index + 1'b1;
                    end
                end
                state_over: begin
                    if (tick) flash <= !flash;
                end
                default: state <= state_init;
            endcase
        end
    end

    always_comb begin
        display               = '0;
        display.round         = round;
        display.highest_round = highest;
        display.state         = state;
        display.game_over     = game_over;
        if (state == state_over) begin
            display.leds = {LED_W{flash}};
        end else if (state == state_show && lit) begin
            if (rd_step.kind == step_led) begin
                display.leds = rd_step.led;
            end else begin
                display.key_show = 1'b1;
                display.key_code = rd_step.key;
            end
        end
    end

    a_index_range: assert property (@(posedge clk) disable iff (reset) rd_index <= seq_len)
        else $error("game_fsm: rd_index beyond the sequence length");

endmodule

//--- game_pkg.sv
package game_pkg;

    // Player panel widths
    localparam int LED_W = 16;                  // LEDs and switches
    localparam int KEY_W = 4;                   // Raw keypad code

    // Round counter for rounds 1 up to the top-level MAX_ROUND
    localparam int ROUND_W = 3;

    // Sequence generator LFSR
    localparam logic [31:0] LFSR_SEED = 32'hABCD_EF01;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // Bits 31, 21, 1, 0

    // Controller states
    typedef enum logic [1:0] {
        state_init,                             // Build or extend the sequence
        state_show,                             // Play the sequence back
        state_input,                            // Player repeats it
        state_over                              // Flash until reset
    } game_state_t;

    // What the player has to do for one step
    typedef enum logic {
        step_led,                               // Toggle the lit switch
        step_key                                // Press the shown key
    } step_kind_t;

    // One sequence entry. Only the field matching kind is nonzero
    typedef struct packed {
        step_kind_t       kind;
        logic [LED_W-1:0] led;                  // One-hot LED pattern
        logic [KEY_W-1:0] key;                  // Keypad code
    } step_t;

endpackage

//--- input_checker.sv
`timescale 1ns/1ps

module input_checker
    import game_pkg::*;
    import panel_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  panel_in_t panel,
    input  logic      check_arm,
    input  logic      capture,
    input  logic      in_show,
    input  step_t     expect_step,
    output logic      step_ok,
    output logic      step_bad
);

    logic [LED_W-1:0] ref_sw;                   // Switch state the player returns to
    logic [LED_W-1:0] sw_prev;
    logic             key_prev;
    logic             judged;                   // Good answer seen and waiting for release
    logic [LED_W-1:0] toggles;
    logic             sw_change;
    logic             key_rise;
    logic             key_fall;
    logic             ok_next;
    logic             bad_next;
    logic             judged_next;

    assign toggles   = panel.switches ^ ref_sw;
    assign sw_change = (panel.switches != sw_prev);
    assign key_rise  = panel.key_valid && !key_prev;
    assign key_fall  = !panel.key_valid && key_prev;

    always_comb begin
        ok_next     = 1'b0;
        bad_next    = 1'b0;
        judged_next = judged;
        if (!check_arm) begin
            judged_next = 1'b0;
        end else if (in_show) begin
            bad_next = sw_change || key_rise;   // Hands off during playback
        end else if (expect_step.kind == step_led) begin
            if (key_rise) begin
                bad_next = 1'b1;
            end else if (sw_change) begin
                if (!judged && toggles == expect_step.led) begin
                    judged_next = 1'b1;
                end else if (judged && toggles == '0) begin
                    ok_next     = 1'b1;         // Switch put back
                    judged_next = 1'b0;
                end else begin
                    bad_next = 1'b1;
                end
            end
        end else begin
            if (sw_change) begin
                bad_next = 1'b1;
            end else if (!judged && key_rise) begin
                if (panel.key_code == expect_step.key) begin
                    judged_next = 1'b1;
                end else begin
                    bad_next = 1'b1;
                end
            end else if (judged && key_fall) begin
                ok_next     = 1'b1;
                judged_next = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ref_sw   <= '0;
            sw_prev  <= '0;
            key_prev <= 1'b0;
            judged   <= 1'b0;
            step_ok  <= 1'b0;
            step_bad <= 1'b0;
        end else begin
            sw_prev  <= panel.switches;
            key_prev <= panel.key_valid;
            judged   <= judged_next;
            step_ok  <= ok_next;
            step_bad <= bad_next;
            if (capture) ref_sw <= panel.switches; // Snapshot before playback
        end
    end

    a_ok_bad_excl: assert property (@(posedge clk) disable iff (reset) !(step_ok && step_bad))
        else $error("input_checker: step_ok and step_bad together");

endmodule

//--- panel_pkg.sv
package panel_pkg;

    import game_pkg::*;

    // Sampled panel levels with one sample per clock
    typedef struct packed {
        logic [LED_W-1:0] switches;
        logic             key_valid;            // High while a key is held
        logic [KEY_W-1:0] key_code;
    } panel_in_t;

    // Everything the board shows to the player
    typedef struct packed {
        logic [LED_W-1:0]   leds;
        logic               key_show;           // Key code below is valid
        logic [KEY_W-1:0]   key_code;           // Raw code without segment encoding
        logic [ROUND_W-1:0] round;
        logic [ROUND_W-1:0] highest_round;
        game_state_t        state;
        logic               game_over;
    } panel_out_t;

endpackage

//--- sequence_gen.sv
`timescale 1ns/1ps

module sequence_gen
    import game_pkg::*;
#(
    parameter int  MAX_STEPS = 5,
    localparam int LEN_W     = $clog2(MAX_STEPS + 1)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [ROUND_W-1:0] round,
    input  logic               gen_start,
    output logic               gen_busy,
    output logic [LEN_W-1:0]   seq_len,
    input  logic [LEN_W-1:0]   rd_index,
    output step_t              rd_step
);

    logic [31:0]      lfsr;
    step_t            mem [MAX_STEPS];
    logic             regen;                    // Current job rebuilds everything
    logic             regen_now;
    logic [LEN_W-1:0] wr_idx;
    logic [LEN_W-1:0] tgt_len;                  // Length once the job is done
    logic [LEN_W-1:0] new_len;
    logic             wr_en;

    // Build one step from the current random word
    function automatic step_t make_step(input logic [31:0] rnd,
                                        input logic [LEN_W-1:0] idx,
                                        input logic early);
        step_t s;
        s.kind = early ? step_kind_t'(rnd[31]) : step_kind_t'(idx[0]);
        s.led  = '0;
        s.key  = '0;
        if (s.kind == step_led) begin
            s.led = LED_W'(1) << rnd[3:0];
        end else begin
            s.key = rnd[KEY_W-1:0];
        end
        return s;
    endfunction

    assign regen_now = ((round % 3) == 0);
    assign new_len   = (round >= MAX_STEPS) ? LEN_W'(MAX_STEPS) : LEN_W'(round);
    assign wr_en     = gen_busy && (regen || (wr_idx < tgt_len));

    // Free running Fibonacci shift
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[30:0], ^(lfsr & LFSR_TAPS)};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            gen_busy <= 1'b0;
            regen    <= 1'b0;
            wr_idx   <= '0;
            tgt_len  <= '0;
            seq_len  <= '0;
        end else if (gen_busy) begin
            // Extend takes one cycle and regenerate walks all entries
            if (!regen || wr_idx == LEN_W'(MAX_STEPS - 1)) begin
                gen_busy <= 1'b0;
                seq_len  <= tgt_len;
            end
            wr_idx <= wr_idx + 1'b1;
        end else if (gen_start) begin
            gen_busy <= 1'b1;
            regen    <= regen_now;
            wr_idx   <= regen_now ? '0 : seq_len; // Append after the kept steps
            tgt_len  <= new_len;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= make_step(lfsr, wr_idx, round <= 3);
        end
    end

    assign rd_step = (rd_index < LEN_W'(MAX_STEPS)) ? mem[rd_index] : '0;

    a_led_onehot: assert property (@(posedge clk) disable iff (reset)
        (!gen_busy && rd_index < seq_len && rd_step.kind == step_led)
            |-> $onehot(rd_step.led))
        else $error("sequence_gen: stored LED step is not one-hot");

endmodule

//--- simon_golden.txt
# id  target_round  action  expected_round  expected_highest_round  expected_game_over
# actions: correct wrong_switch wrong_key wrong_type early
1  1 correct      2 2 0
2  2 correct      3 3 0
3  3 correct      4 4 0
4  5 correct      6 6 0
5  7 correct      7 7 0
6  2 wrong_switch 2 2 1
7  4 wrong_key    4 4 1
8  3 wrong_type   3 3 1
9  6 wrong_type   6 6 1
10 1 early        1 1 1
11 5 early        5 5 1
12 7 wrong_switch 7 7 1
13 4 wrong_switch 4 4 1
14 6 wrong_key    6 6 1

//--- simon_top.sv
`timescale 1ns/1ps

module simon_top
    import game_pkg::*;
    import panel_pkg::*;
#(
    parameter int TICK_CYCLES = 50_000_000,
    parameter int MAX_STEPS   = 5,
    parameter int MAX_ROUND   = 7
) (
    input  logic       clk,
    input  logic       reset,
    input  panel_in_t  panel,
    output panel_out_t display
);

    localparam int LEN_W = $clog2(MAX_STEPS + 1);

    logic               tick;
    logic               tick_enable;
    logic [ROUND_W-1:0] round;
    logic               gen_start;
    logic               gen_busy;
    logic [LEN_W-1:0]   seq_len;
    logic [LEN_W-1:0]   rd_index;
    step_t              rd_step;                // Also the expected step
    logic               check_arm;
    logic               capture;
    logic               in_show;
    logic               step_ok;
    logic               step_bad;

    step_timer #(.TICK_CYCLES(TICK_CYCLES)) u_timer (
        .clk, .reset, .tick_enable, .round, .tick
    );

    sequence_gen #(.MAX_STEPS(MAX_STEPS)) u_seq (
        .clk, .reset, .round, .gen_start, .gen_busy, .seq_len, .rd_index, .rd_step
    );

    input_checker u_check (
        .clk, .reset, .panel, .check_arm, .capture, .in_show,
        .expect_step(rd_step), .step_ok, .step_bad
    );

    game_fsm #(.MAX_STEPS(MAX_STEPS), .MAX_ROUND(MAX_ROUND)) u_fsm (
        .clk, .reset, .tick, .gen_busy, .seq_len, .rd_step, .step_ok, .step_bad,
        .gen_start, .tick_enable, .rd_index, .check_arm, .capture, .in_show,
        .round, .display
    );

endmodule

//--- step_timer.sv
`timescale 1ns/1ps

module step_timer
    import game_pkg::*;
#(
    parameter int TICK_CYCLES = 50_000_000
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               tick_enable,
    input  logic [ROUND_W-1:0] round,
    output logic               tick
);

    // Periods per round group never drop below two cycles
    localparam int PER_1 = (TICK_CYCLES > 2) ? TICK_CYCLES : 2;
    localparam int PER_2 = (TICK_CYCLES / 2 > 2) ? TICK_CYCLES / 2 : 2;
    localparam int PER_4 = (TICK_CYCLES / 4 > 2) ? TICK_CYCLES / 4 : 2;
    localparam int PER_8 = (TICK_CYCLES / 8 > 2) ? TICK_CYCLES / 8 : 2;
    localparam int CNT_W = $clog2(PER_1);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] limit;                    // Last count of the period

    always_comb begin
        case (round)
            3'd3, 3'd4: limit = CNT_W'(PER_2 - 1);
            3'd5, 3'd6: limit = CNT_W'(PER_4 - 1);
            3'd7:       limit = CNT_W'(PER_8 - 1);
            default:    limit = CNT_W'(PER_1 - 1); // Rounds 1 and 2
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (!tick_enable) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt >= limit) begin        // Also catches a faster round
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    a_tick_single: assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
        else $error("step_timer: tick high on two cycles in a row");

endmodule

//--- tb_simon.sv
`timescale 1ns/1ps

module tb_simon
    import game_pkg::*;
    import panel_pkg::*;
();

    localparam int TICK_CYCLES = 8;
    localparam int MAX_STEPS   = 5;
    localparam int MAX_ROUND   = 7;

    logic       clk;
    logic       reset;
    panel_in_t  panel;
    panel_out_t display;

    int          sc_id[$];
    int          sc_target[$];
    logic [127:0] sc_action[$];                 // Action word from the golden file
    int          sc_round[$];
    int          sc_high[$];
    int          sc_over[$];
    step_t       shown[$];                      // Steps seen in the current playback
    step_t       prev[$];
    logic [31:0] rnd_state;
    longint      wd_limit;

    simon_top #(
        .TICK_CYCLES(TICK_CYCLES),
        .MAX_STEPS(MAX_STEPS),
        .MAX_ROUND(MAX_ROUND)
    ) DUT (
        .clk, .reset, .panel, .display
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps 32, 30, 26, 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[29] ^ s[25] ^ s[24]};
    endfunction

    task automatic draw_bits(input int n, output logic [3:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            rnd_state = lfsr_step(rnd_state);
            v = {v[2:0], rnd_state[0]};
        end
    endtask

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_round(input logic [ROUND_W-1:0] got, input logic [ROUND_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "round mismatch");
        end
    endtask

    task automatic check_step(input step_t got, input step_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "step mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // Inputs change shortly after the rising edge
    task automatic hold(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic load_scenarios;
        int           fd;
        int           n;
        int           id, tgt, er, eh, eo;
        logic [127:0] act;
        logic [8*120-1:0] line;
        fd = $fopen("simon_golden.txt", "r");
        if (fd == 0) fail_now("cannot open simon_golden.txt");
        while (!$feof(fd)) begin
            line = '0;
            void'($fgets(line, fd));
            n = $sscanf(line, "%d %d %s %d %d %d", id, tgt, act, er, eh, eo);
            if (n == 6) begin                   // Comment and blank lines give fewer
                if (act != "correct" && act != "wrong_switch" && act != "wrong_key" &&
                    act != "wrong_type" && act != "early")
                    fail_now("unknown action in simon_golden.txt");
                sc_id.push_back(id);
                sc_target.push_back(tgt);
                sc_action.push_back(act);
                sc_round.push_back(er);
                sc_high.push_back(eh);
                sc_over.push_back(eo);
            end
        end
        $fclose(fd);
        if (sc_id.size() == 0) fail_now("simon_golden.txt holds no scenarios");
    endtask

    // Generous bound on the playback and replay time of all scenarios
    function automatic longint run_time_limit();
        longint t;
        t = 40 * 1000;                          // Reset and flashing margin
        foreach (sc_target[k])
            t += longint'(sc_target[k] + 2) * MAX_STEPS * 4 * (TICK_CYCLES + 8) * 40;
        return t;
    endfunction

    task automatic apply_reset;
        @(posedge clk);
        #2;
        reset = 1'b1;
        panel = '0;
        hold(16);
        reset = 1'b0;
        @(negedge clk);
        check_round(display.round, ROUND_W'(1), "round after reset");
        check_round(display.highest_round, ROUND_W'(1), "highest_round after reset");
        check_flag(display.game_over, 1'b0, "game_over after reset");
    endtask

    // Collects the playback and optionally touches a switch after the first step
    task automatic record_show(input bit disturb);
        logic  was_lit;
        logic  now_lit;
        step_t s;
        bit    done_disturb;
        shown.delete();
        was_lit = 1'b0;
        done_disturb = 0;
        while (display.state != state_show) @(negedge clk);
        while (display.state == state_show) begin
            now_lit = (display.leds != '0) || display.key_show;
            if (now_lit && !was_lit) begin
                s.kind = display.key_show ? step_key : step_led;
                s.led  = display.key_show ? '0 : display.leds;
                s.key  = display.key_show ? display.key_code : '0;
                shown.push_back(s);
            end
            was_lit = now_lit;
            if (disturb && !done_disturb && shown.size() > 0) begin
                @(posedge clk);
                #2;
                panel.switches[0] = ~panel.switches[0];
                done_disturb = 1;
            end
            @(negedge clk);
        end
    endtask

    task automatic play_step(input step_t s);
        hold(1);
        if (s.kind == step_led) begin
            panel.switches = panel.switches ^ s.led;
            hold(2);
            panel.switches = panel.switches ^ s.led; // Back to the reference state
        end else begin
            panel.key_code  = s.key;
            panel.key_valid = 1'b1;
            hold(2);
            panel.key_valid = 1'b0;
        end
        hold(3);
    endtask

    // Answers wrongly at the first step of the kind the action needs
    task automatic wrong_answer(input logic [127:0] act);
        logic [3:0] pick;
        int         at;
        step_kind_t need;
        step_t      exp;
        need = (act == "wrong_key") ? step_key : step_led;
        at   = 0;
        if (act != "wrong_type")
            while (at < shown.size() - 1 && shown[at].kind != need) at++;
        for (int i = 0; i < at; i++) play_step(shown[i]);
        exp = shown[at];
        draw_bits(4, pick);
        if (act == "wrong_key" || (act == "wrong_type" && exp.kind == step_led)) begin
            while (exp.kind == step_key && pick == exp.key) draw_bits(4, pick);
            hold(1);
            panel.key_code  = pick;
            panel.key_valid = 1'b1;
        end else begin
            while ((LED_W'(1) << pick) == exp.led) draw_bits(4, pick);
            hold(1);
            panel.switches[pick] = ~panel.switches[pick];
        end
    endtask

    task automatic check_flashing;
        logic [LED_W-1:0] last;
        int               changes;
        changes = 0;
        check_flag(display.state == state_over, 1'b1, "state is state_over");
        last = display.leds;
        while (changes < 2) begin
            @(negedge clk);
            check_flag(display.leds == '0 || display.leds == '1, 1'b1, "leds all on or off");
            if (display.leds != last) changes++;
            last = display.leds;
        end
    endtask

    task automatic run_scenario(input int k);
        int           tgt;
        int           want;
        logic [127:0] act;
        bit           early;
        tgt = sc_target[k];
        act = sc_action[k];
        apply_reset;
        prev.delete();
        for (int r = 1; r <= tgt; r++) begin
            early = (r == tgt) && (act == "early");
            record_show(early);
            if (early) break;
            want = (r < MAX_STEPS) ? r : MAX_STEPS;
            check_round(ROUND_W'(shown.size()), ROUND_W'(want), "steps shown");
            foreach (shown[i])
                if (shown[i].kind == step_led)
                    check_flag($onehot(shown[i].led), 1'b1, "shown LED step one-hot");
            if (r % 3 != 0)
                foreach (prev[i]) check_step(shown[i], prev[i], "kept step");
            prev = shown;
            if (r < tgt || act == "correct") begin
                foreach (shown[i]) play_step(shown[i]);
                while (display.state == state_input) @(negedge clk);
                want = (r < MAX_ROUND) ? r + 1 : MAX_ROUND;
                check_round(display.round, ROUND_W'(want), "round after replay");
                check_round(display.highest_round, ROUND_W'(want), "highest_round");
            end else begin
                wrong_answer(act);
            end
        end
        if (act != "correct") begin
            while (!display.game_over) @(negedge clk);
            check_flashing;
        end
        check_round(display.round, ROUND_W'(sc_round[k]), "final round");
        check_round(display.highest_round, ROUND_W'(sc_high[k]), "final highest_round");
        check_flag(display.game_over, sc_over[k][0], "final game_over");
    endtask

    // Watchdog armed once the scenario list is known
    initial begin
        wait (wd_limit > 0);
        #(wd_limit);
        $display("watchdog expired, the run hung");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        reset     = 1'b1;
        panel     = '0;
        rnd_state = 32'h400e8dad;
        wd_limit  = 0;
        load_scenarios;
        wd_limit = run_time_limit();
        foreach (sc_id[k]) run_scenario(k);
        $display("Test OK");
        $finish;
    end

endmodule
